// ==== rtl/uart_pkg.sv ====
package uart_pkg;

  // ------------------------------------------------------------------------
  // widths
  // ------------------------------------------------------------------------
  localparam int DATA_W     = 8;    // character width, fixed 8N1
  localparam int WB_DW      = 32;   // wishbone data bus
  localparam int OVERSAMPLE = 16;   // baud ticks per serial bit
  localparam int DIV_W      = 16;   // baud divisor width

  // register map on the 2-bit wishbone address
  typedef enum logic [1:0] {
    ADDR_DATA   = 2'd0,  // write pushes tx fifo, read pops rx fifo
    ADDR_STATUS = 2'd1,  // line status, read clears overrun
    ADDR_CTRL   = 2'd2,  // divisor and interrupt enables
    ADDR_IIR    = 2'd3   // interrupt identification, read only
  } reg_addr_e;

  // ------------------------------------------------------------------------
  // state machines
  // ------------------------------------------------------------------------
  typedef enum logic [1:0] {
    TX_IDLE,
    TX_START,
    TX_DATA,
    TX_STOP
  } tx_state_e;

  typedef enum logic [1:0] {
    RX_IDLE,
    RX_START,
    RX_DATA,
    RX_STOP
  } rx_state_e;

  // iir bits 3:1, higher code wins
  typedef enum logic [2:0] {
    II_NONE = 3'b000,
    II_THRE = 3'b001,
    II_RDA  = 3'b010,
    II_RLS  = 3'b011
  } iir_code_e;

  // line status bit positions
  localparam int LS_DR  = 0;  // rx fifo not empty
  localparam int LS_OE  = 1;  // sticky overrun
  localparam int LS_TFE = 5;  // tx fifo empty
  localparam int LS_TE  = 6;  // tx fifo empty and shifter idle

  // control register fields
  localparam int CTRL_DIV_LSB = 0;
  localparam int CTRL_IE_RDA  = 16;
  localparam int CTRL_IE_THRE = 17;
  localparam int CTRL_IE_RLS  = 18;

endpackage

// ==== rtl/uart_fifo.sv ====
module uart_fifo #(
  parameter int FIFO_DEPTH = 16       // power of two
) (
  input  logic                        clk,
  input  logic                        arst_n_i,
  input  logic                        push_i,
  input  logic [uart_pkg::DATA_W-1:0] wdata_i,
  input  logic                        pop_i,
  output logic [uart_pkg::DATA_W-1:0] rdata_o,   // head, valid when not empty
  output logic                        full_o,
  output logic                        empty_o
);
  import uart_pkg::*;

  localparam int AW    = $clog2(FIFO_DEPTH);
  localparam int CNT_W = AW + 1;

  logic [DATA_W-1:0] mem [FIFO_DEPTH];
  logic [AW-1:0]     wr_ptr_q;
  logic [AW-1:0]     rd_ptr_q;
  logic [CNT_W-1:0]  count_q;
  logic              do_push;
  logic              do_pop;

  assign full_o  = (count_q == CNT_W'(FIFO_DEPTH));
  assign empty_o = (count_q == '0);
  assign do_push = push_i & ~full_o;    // push on full is ignored
  assign do_pop  = pop_i & ~empty_o;    // pop on empty is ignored
  assign rdata_o = mem[rd_ptr_q];

  // storage
  always_ff @(posedge clk)
  begin
    if (do_push)
      mem[wr_ptr_q] <= wdata_i;
  end

  // pointers wrap on their own since depth is a power of two
  always_ff @(posedge clk or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end
    else
    begin
      if (do_push)
        wr_ptr_q <= wr_ptr_q + 1'b1;
      if (do_pop)
        rd_ptr_q <= rd_ptr_q + 1'b1;
      case ({do_push, do_pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;        // both or neither
      endcase
    end
  end

endmodule

// ==== rtl/uart_baud_gen.sv ====
module uart_baud_gen (
  input  logic                       clk,
  input  logic                       arst_n_i,
  input  logic [uart_pkg::DIV_W-1:0] divisor_i,
  output logic                       tick_o     // one cycle in every divisor
);
  import uart_pkg::*;

  logic [DIV_W-1:0] cnt_q;
  logic [DIV_W-1:0] div_q;  // last divisor, to spot a rewrite

  always_ff @(posedge clk or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      cnt_q  <= '0;
      div_q  <= '0;
      tick_o <= 1'b0;
    end
    else
    begin
      div_q  <= divisor_i;
      tick_o <= 1'b0;
      if (divisor_i == '0)
        cnt_q <= '0;                       // stopped
      else if (divisor_i != div_q)
        cnt_q <= divisor_i - 1'b1;         // new rate, restart count
      else if (cnt_q == '0)
      begin
        cnt_q  <= divisor_i - 1'b1;        // reload
        tick_o <= 1'b1;
      end
      else
        cnt_q <= cnt_q - 1'b1;
    end
  end

endmodule

// ==== rtl/uart_tx.sv ====
module uart_tx (
  input  logic                        clk,
  input  logic                        arst_n_i,
  input  logic                        tick_i,
  input  logic                        fifo_empty_i,
  input  logic [uart_pkg::DATA_W-1:0] fifo_data_i,
  output logic                        fifo_pop_o,
  output logic                        busy_o,
  output logic                        stx_o
);
  import uart_pkg::*;

  tx_state_e         state_q;
  logic [3:0]        tick_cnt_q;  // ticks within the current bit
  logic [2:0]        bit_idx_q;
  logic [DATA_W-1:0] shreg_q;     // lsb goes out first
  logic              bit_end;     // last tick of a bit

  assign bit_end    = tick_i && (tick_cnt_q == 4'(OVERSAMPLE - 1));
  assign fifo_pop_o = (state_q == TX_IDLE) && tick_i && !fifo_empty_i;
  assign busy_o     = (state_q != TX_IDLE);

  // --------------------------------------------------------------------------
  // frame sequencing
  // --------------------------------------------------------------------------
  always_ff @(posedge clk or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      state_q    <= TX_IDLE;
      tick_cnt_q <= '0;
      bit_idx_q  <= '0;
    end
    else
    begin
      if (state_q == TX_IDLE)
        tick_cnt_q <= '0;
      else if (tick_i)
        tick_cnt_q <= bit_end ? 4'd0 : tick_cnt_q + 1'b1;

      case (state_q)
        TX_IDLE:
        begin
          bit_idx_q <= '0;
          if (fifo_pop_o)
            state_q <= TX_START;
        end
        TX_START:
          if (bit_end)
            state_q <= TX_DATA;
        TX_DATA:
          if (bit_end)
          begin
            bit_idx_q <= bit_idx_q + 1'b1;
            if (bit_idx_q == 3'(DATA_W - 1))
              state_q <= TX_STOP;               // all 8 bits out
          end
        default:
          if (bit_end)
            state_q <= TX_IDLE;                 // stop bit done
      endcase
    end
  end

  // payload shift register
  always_ff @(posedge clk)
  begin
    if (fifo_pop_o)
      shreg_q <= fifo_data_i;
    else if ((state_q == TX_DATA) && bit_end)
      shreg_q <= shreg_q >> 1;
  end

  // line level from state, idle and stop are high
  always_comb
  begin
    case (state_q)
      TX_START: stx_o = 1'b0;
      TX_DATA:  stx_o = shreg_q[0];
      default:  stx_o = 1'b1;
    endcase
  end

endmodule

// ==== rtl/uart_rx.sv ====
module uart_rx (
  input  logic                        clk,
  input  logic                        arst_n_i,
  input  logic                        tick_i,
  input  logic                        srx_i,       // async serial in
  output logic                        rx_valid_o,  // one-cycle push
  output logic [uart_pkg::DATA_W-1:0] rx_byte_o
);
  import uart_pkg::*;

  rx_state_e  state_q;
  logic       sync1_q;
  logic       sync2_q;        // synchronized line
  logic       prev_q;         // for falling edge
  logic [3:0] tick_cnt_q;
  logic [2:0] bit_idx_q;
  logic       fall;
  logic       half_end;       // mid start bit
  logic       bit_end;        // mid of the next bit

  // --------------------------------------------------------------------------
  // input synchronizer, idle high out of reset
  // --------------------------------------------------------------------------
  always_ff @(posedge clk or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      sync1_q <= 1'b1;
      sync2_q <= 1'b1;
      prev_q  <= 1'b1;
    end
    else
    begin
      sync1_q <= srx_i;
      sync2_q <= sync1_q;
      prev_q  <= sync2_q;
    end
  end

  assign fall     = prev_q & ~sync2_q;
  assign half_end = tick_i && (tick_cnt_q == 4'(OVERSAMPLE / 2 - 1));
  assign bit_end  = tick_i && (tick_cnt_q == 4'(OVERSAMPLE - 1));

  // --------------------------------------------------------------------------
  // receive fsm
  // --------------------------------------------------------------------------
  always_ff @(posedge clk or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      state_q    <= RX_IDLE;
      tick_cnt_q <= '0;
      bit_idx_q  <= '0;
      rx_valid_o <= 1'b0;
    end
    else
    begin
      rx_valid_o <= 1'b0;
      case (state_q)
        RX_IDLE:
        begin
          tick_cnt_q <= '0;
          bit_idx_q  <= '0;
          if (fall)
            state_q <= RX_START;
        end
        RX_START:
          if (half_end)
          begin
            tick_cnt_q <= '0;
            state_q    <= sync2_q ? RX_IDLE : RX_DATA;  // glitch, not a start
          end
          else if (tick_i)
            tick_cnt_q <= tick_cnt_q + 1'b1;
        RX_DATA:
          if (bit_end)
          begin
            tick_cnt_q <= '0;
            bit_idx_q  <= bit_idx_q + 1'b1;
            if (bit_idx_q == 3'(DATA_W - 1))
              state_q <= RX_STOP;
          end
          else if (tick_i)
            tick_cnt_q <= tick_cnt_q + 1'b1;
        default:
          if (bit_end)
          begin
            rx_valid_o <= sync2_q;      // low stop bit drops the frame
            state_q    <= RX_IDLE;
          end
          else if (tick_i)
            tick_cnt_q <= tick_cnt_q + 1'b1;
      endcase
    end
  end

  // data bits arrive lsb first, shift in from the top
  always_ff @(posedge clk)
  begin
    if ((state_q == RX_DATA) && bit_end)
      rx_byte_o <= {sync2_q, rx_byte_o[DATA_W-1:1]};
  end

endmodule

// ==== rtl/uart_regs.sv ====
module uart_regs #(
  parameter int FIFO_DEPTH = 16
) (
  input  logic                        clk,
  input  logic                        arst_n_i,
  input  logic                        wb_cyc_i,
  input  logic                        wb_stb_i,
  input  logic                        wb_we_i,
  input  logic [1:0]                  wb_adr_i,
  input  logic [uart_pkg::WB_DW-1:0]  wb_dat_i,
  output logic [uart_pkg::WB_DW-1:0]  wb_dat_o,
  output logic                        wb_ack_o,
  input  logic                        tx_full_i,
  input  logic                        tx_empty_i,
  input  logic                        tx_busy_i,
  input  logic                        rx_valid_i,
  input  logic                        rx_full_i,
  input  logic                        rx_empty_i,
  input  logic [uart_pkg::DATA_W-1:0] rx_rdata_i,
  output logic                        tx_push_o,
  output logic [uart_pkg::DATA_W-1:0] tx_wdata_o,
  output logic                        rx_pop_o,
  output logic [uart_pkg::DIV_W-1:0]  divisor_o,
  output logic                        int_o
);
  import uart_pkg::*;

  localparam int CNT_W = $clog2(FIFO_DEPTH) + 1;  // holds 0..FIFO_DEPTH

  reg_addr_e        adr;
  logic             req;        // cyc and stb
  logic             wr_acc;     // write taking effect this cycle
  logic             rd_acc;     // read taking effect this cycle
  logic [DIV_W-1:0] div_q;
  logic             ie_rda_q;
  logic             ie_thre_q;
  logic             ie_rls_q;
  logic             oe_q;       // sticky rx overrun
  logic             dr;
  logic             te;
  logic             rls_c;
  logic             rda_c;
  logic             thre_c;
  iir_code_e        iir_code;
  logic [WB_DW-1:0] ctrl_word;
  logic [WB_DW-1:0] status_word;
  logic [WB_DW-1:0] iir_word;
  logic [WB_DW-1:0] data_word;

  // --------------------------------------------------------------------------
  // wishbone handshake
  // --------------------------------------------------------------------------
  assign adr    = reg_addr_e'(wb_adr_i);
  assign req    = wb_cyc_i & wb_stb_i;
  assign wr_acc = req & wb_ack_o & wb_we_i;   // side effects happen with ack
  assign rd_acc = req & wb_ack_o & ~wb_we_i;

  // single-cycle ack, one clock after the request
  always_ff @(posedge clk or negedge arst_n_i)
  begin
    if (!arst_n_i)
      wb_ack_o <= 1'b0;
    else
      wb_ack_o <= req & ~wb_ack_o;
  end

  assign tx_push_o  = wr_acc && (adr == ADDR_DATA) && !tx_full_i;  // full drops it
  assign tx_wdata_o = wb_dat_i[DATA_W-1:0];
  assign rx_pop_o   = rd_acc && (adr == ADDR_DATA) && !rx_empty_i;

  // control register
  always_ff @(posedge clk or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      div_q     <= '0;        // zero divisor keeps the baud gen quiet
      ie_rda_q  <= 1'b0;
      ie_thre_q <= 1'b0;
      ie_rls_q  <= 1'b0;
    end
    else if (wr_acc && (adr == ADDR_CTRL))
    begin
      div_q     <= wb_dat_i[CTRL_DIV_LSB +: DIV_W];
      ie_rda_q  <= wb_dat_i[CTRL_IE_RDA];
      ie_thre_q <= wb_dat_i[CTRL_IE_THRE];
      ie_rls_q  <= wb_dat_i[CTRL_IE_RLS];
    end
  end

  assign divisor_o = div_q;

  // overrun: byte arrives while rx fifo is full, set beats clear
  always_ff @(posedge clk or negedge arst_n_i)
  begin
    if (!arst_n_i)
      oe_q <= 1'b0;
    else if (rx_valid_i && rx_full_i)
      oe_q <= 1'b1;
    else if (rd_acc && (adr == ADDR_STATUS))
      oe_q <= 1'b0;
  end

  // --------------------------------------------------------------------------
  // status, iir and interrupt
  // --------------------------------------------------------------------------
  assign dr     = ~rx_empty_i;
  assign te     = tx_empty_i & ~tx_busy_i;
  assign rls_c  = ie_rls_q & oe_q;
  assign rda_c  = ie_rda_q & dr;     // no trigger level, any byte counts
  assign thre_c = ie_thre_q & te;

  always_comb
  begin
    // priority: line status, then rx data, then tx empty
    if (rls_c)
      iir_code = II_RLS;
    else if (rda_c)
      iir_code = II_RDA;
    else if (thre_c)
      iir_code = II_THRE;
    else
      iir_code = II_NONE;
  end

  always_comb
  begin
    status_word                 = '0;
    status_word[LS_DR]          = dr;
    status_word[LS_OE]          = oe_q;
    status_word[LS_TFE]         = tx_empty_i;
    status_word[LS_TE]          = te;
    status_word[16 +: CNT_W]    = CNT_W'(FIFO_DEPTH);  // fifo depth, read only

    iir_word      = '0;
    iir_word[3:1] = iir_code;
    iir_word[0]   = (iir_code == II_NONE);   // low means pending

    ctrl_word                          = '0;
    ctrl_word[CTRL_DIV_LSB +: DIV_W]   = div_q;
    ctrl_word[CTRL_IE_RDA]             = ie_rda_q;
    ctrl_word[CTRL_IE_THRE]            = ie_thre_q;
    ctrl_word[CTRL_IE_RLS]             = ie_rls_q;

    data_word = '0;
    if (!rx_empty_i)
      data_word[DATA_W-1:0] = rx_rdata_i;   // empty fifo reads as zero
  end

  // read mux, sampled by the master while ack is high
  always_comb
  begin
    case (adr)
      ADDR_DATA:   wb_dat_o = data_word;
      ADDR_STATUS: wb_dat_o = status_word;
      ADDR_CTRL:   wb_dat_o = ctrl_word;
      default:     wb_dat_o = iir_word;
    endcase
  end

  // level interrupt, one cycle behind its condition
  always_ff @(posedge clk or negedge arst_n_i)
  begin
    if (!arst_n_i)
      int_o <= 1'b0;
    else
      int_o <= rls_c | rda_c | thre_c;
  end

endmodule

// ==== rtl/uart_top.sv ====
module uart_top #(
  parameter int FIFO_DEPTH = 16
) (
  input  logic                       clk,
  input  logic                       arst_n_i,
  input  logic                       wb_cyc_i,
  input  logic                       wb_stb_i,
  input  logic                       wb_we_i,
  input  logic [1:0]                 wb_adr_i,
  input  logic [uart_pkg::WB_DW-1:0] wb_dat_i,
  output logic [uart_pkg::WB_DW-1:0] wb_dat_o,
  output logic                       wb_ack_o,
  input  logic                       srx_i,     // serial in, idle high
  output logic                       stx_o,     // serial out
  output logic                       int_o
);
  import uart_pkg::*;

  logic [DIV_W-1:0]  divisor;
  logic              tick;      // 16x bit rate strobe

  // transmit path
  logic              tx_push;
  logic [DATA_W-1:0] tx_wdata;
  logic              tx_pop;
  logic [DATA_W-1:0] tx_rdata;
  logic              tx_full;
  logic              tx_empty;
  logic              tx_busy;

  // receive path
  logic              rx_valid;
  logic [DATA_W-1:0] rx_byte;
  logic              rx_pop;
  logic [DATA_W-1:0] rx_rdata;
  logic              rx_full;
  logic              rx_empty;

  uart_regs #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) u_regs (
    .clk        (clk),
    .arst_n_i   (arst_n_i),
    .wb_cyc_i   (wb_cyc_i),
    .wb_stb_i   (wb_stb_i),
    .wb_we_i    (wb_we_i),
    .wb_adr_i   (wb_adr_i),
    .wb_dat_i   (wb_dat_i),
    .wb_dat_o   (wb_dat_o),
    .wb_ack_o   (wb_ack_o),
    .tx_full_i  (tx_full),
    .tx_empty_i (tx_empty),
    .tx_busy_i  (tx_busy),
    .rx_valid_i (rx_valid),
    .rx_full_i  (rx_full),
    .rx_empty_i (rx_empty),
    .rx_rdata_i (rx_rdata),
    .tx_push_o  (tx_push),
    .tx_wdata_o (tx_wdata),
    .rx_pop_o   (rx_pop),
    .divisor_o  (divisor),
    .int_o      (int_o)
  );

  uart_baud_gen u_baud_gen (
    .clk       (clk),
    .arst_n_i  (arst_n_i),
    .divisor_i (divisor),
    .tick_o    (tick)
  );

  uart_fifo #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) u_tx_fifo (
    .clk      (clk),
    .arst_n_i (arst_n_i),
    .push_i   (tx_push),
    .wdata_i  (tx_wdata),
    .pop_i    (tx_pop),
    .rdata_o  (tx_rdata),
    .full_o   (tx_full),
    .empty_o  (tx_empty)
  );

  uart_fifo #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) u_rx_fifo (
    .clk      (clk),
    .arst_n_i (arst_n_i),
    .push_i   (rx_valid),  // no back-pressure, full drops the byte
    .wdata_i  (rx_byte),
    .pop_i    (rx_pop),
    .rdata_o  (rx_rdata),
    .full_o   (rx_full),
    .empty_o  (rx_empty)
  );

  uart_tx u_tx (
    .clk          (clk),
    .arst_n_i     (arst_n_i),
    .tick_i       (tick),
    .fifo_empty_i (tx_empty),
    .fifo_data_i  (tx_rdata),
    .fifo_pop_o   (tx_pop),
    .busy_o       (tx_busy),
    .stx_o        (stx_o)
  );

  uart_rx u_rx (
    .clk        (clk),
    .arst_n_i   (arst_n_i),
    .tick_i     (tick),
    .srx_i      (srx_i),
    .rx_valid_o (rx_valid),
    .rx_byte_o  (rx_byte)
  );

endmodule

// ==== bench/tb_clkgen.sv ====
module tb_clkgen (
  output logic clk,
  output logic arst_n_o
);
  timeunit 1ns;
  timeprecision 100ps;

  localparam realtime HALF_PERIOD = 4ns;  // 8 ns clock

  initial
  begin
    clk = 1'b0;
    forever #(HALF_PERIOD) clk = ~clk;
  end

  // reset held low for three rising edges, released on a falling edge
  initial
  begin
    arst_n_o = 1'b0;
    repeat (3) @(posedge clk);
    @(negedge clk);
    arst_n_o = 1'b1;
  end

endmodule

// ==== bench/uart_tb.sv ====
module uart_tb;
  timeunit 1ns;
  timeprecision 100ps;
  import uart_pkg::*;

  localparam int          DEPTH      = 4;
  localparam int          BIT_CYC    = 32;      // 16 ticks of divisor 2
  localparam int          MAX_CYCLES = 20000;   // ten frames of 320 cycles plus bus traffic
  localparam logic [31:0] DIV_CFG    = 32'd2;
  localparam logic [31:0] IE_RDA     = 32'd1 << CTRL_IE_RDA;
  localparam logic [31:0] IE_THRE    = 32'd1 << CTRL_IE_THRE;
  localparam logic [31:0] IE_RLS     = 32'd1 << CTRL_IE_RLS;

  logic        clk;
  logic        arst_n;
  logic        wb_cyc;
  logic        wb_stb;
  logic        wb_we;
  logic [1:0]  wb_adr;
  logic [31:0] wb_dat_w;
  logic [31:0] wb_dat_r;
  logic        wb_ack;
  logic        srx;
  logic        stx;
  logic        irq;
  int          cycles = 0;

  tb_clkgen u_clkgen (
    .clk      (clk),
    .arst_n_o (arst_n)
  );

  uart_top #(
    .FIFO_DEPTH (DEPTH)
  ) dut (
    .clk      (clk),
    .arst_n_i (arst_n),
    .wb_cyc_i (wb_cyc),
    .wb_stb_i (wb_stb),
    .wb_we_i  (wb_we),
    .wb_adr_i (wb_adr),
    .wb_dat_i (wb_dat_w),
    .wb_dat_o (wb_dat_r),
    .wb_ack_o (wb_ack),
    .srx_i    (srx),
    .stx_o    (stx),
    .int_o    (irq)
  );

  assign srx = stx;  // serial loopback

  // --------------------------------------------------------------------------
  // failure handling and checks
  // --------------------------------------------------------------------------
  task automatic fail_run(input string what);
    $display("%s", what);
    $display("** FAIL **");
    $fatal(1, "run stopped at cycle %0d", cycles);
  endtask

  task automatic check_eq(input string name, input logic [31:0] exp, input logic [31:0] act);
    assert (act === exp)
    else
      fail_run($sformatf("ERR %s expected 0x%0h actual 0x%0h", name, exp, act));
  endtask

  // ack is a single pulse and only answers a request
  ack_one_cycle: assert property (@(posedge clk) disable iff (!arst_n) wb_ack |=> !wb_ack)
    else fail_run("wishbone ack stayed high for more than one cycle");
  ack_after_req: assert property (@(posedge clk) disable iff (!arst_n)
                                  $rose(wb_ack) |-> $past(wb_cyc && wb_stb))
    else fail_run("wishbone ack rose without a request");

  always @(posedge clk)
  begin
    cycles <= cycles + 1;
    if (cycles == MAX_CYCLES)
      fail_run("timeout, the tests did not finish within the cycle limit");
  end

  // --------------------------------------------------------------------------
  // wishbone master, driven on falling edges
  // --------------------------------------------------------------------------
  task automatic wb_access(input logic we, input reg_addr_e adr, input logic [31:0] wdata,
                           output logic [31:0] rdata);
    @(negedge clk);
    wb_cyc   = 1'b1;
    wb_stb   = 1'b1;
    wb_we    = we;
    wb_adr   = adr;
    wb_dat_w = wdata;
    @(negedge clk);
    while (wb_ack !== 1'b1)
      @(negedge clk);
    rdata = wb_dat_r;       // valid while ack high
    @(negedge clk);         // hold stb across the acking edge
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
  endtask

  task automatic wb_write(input reg_addr_e adr, input logic [31:0] data);
    logic [31:0] unused;
    wb_access(1'b1, adr, data, unused);
  endtask

  task automatic wb_read(input reg_addr_e adr, output logic [31:0] data);
    wb_access(1'b0, adr, '0, data);
  endtask

  // poll status until every bit of mask is set
  task automatic wait_status(input logic [31:0] mask);
    logic [31:0] st;
    st = '0;
    while ((st & mask) != mask)
      wb_read(ADDR_STATUS, st);
  endtask

  // --------------------------------------------------------------------------
  // stimulus
  // --------------------------------------------------------------------------
  initial
  begin
    logic [31:0] rd;
    logic [7:0]  b;
    logic [9:0]  frame;
    logic [7:0]  sent [$];
    int unsigned seed_dummy;

    wb_cyc     = 1'b0;
    wb_stb     = 1'b0;
    wb_we      = 1'b0;
    wb_adr     = '0;
    wb_dat_w   = '0;
    seed_dummy = $urandom(46);

    // reset state
    @(posedge arst_n);
    @(negedge clk);
    check_eq("reset_stx", 1, stx);
    check_eq("reset_int", 0, irq);
    wb_read(ADDR_STATUS, rd);
    check_eq("reset_status", (32'd1 << LS_TFE) | (32'd1 << LS_TE),
             rd & ((32'd1 << LS_DR) | (32'd1 << LS_OE) | (32'd1 << LS_TFE) | (32'd1 << LS_TE)));
    wb_read(ADDR_IIR, rd);
    check_eq("reset_iir", 32'h1, rd);
    wb_write(ADDR_CTRL, DIV_CFG);

    // frame format, checked every cycle of every bit
    b     = 8'($urandom());
    frame = {1'b1, b, 1'b0};  // stop, data lsb first, start
    wb_write(ADDR_DATA, {24'd0, b});
    while (stx !== 1'b0)
      @(negedge clk);
    for (int k = 0; k < 10; k++)
      for (int c = 0; c < BIT_CYC; c++)
      begin
        check_eq("frame_level", frame[k], stx);
        @(negedge clk);
      end
    wait_status(32'd1 << LS_DR);
    wb_read(ADDR_DATA, rd);
    check_eq("frame_echo", b, rd);

    // loopback order
    for (int i = 0; i < 3; i++)
    begin
      sent.push_back(8'($urandom()));
      wb_write(ADDR_DATA, {24'd0, sent[i]});
    end
    wait_status((32'd1 << LS_DR) | (32'd1 << LS_TE));
    for (int i = 0; i < 3; i++)
    begin
      wb_read(ADDR_DATA, rd);
      check_eq("loop_order", sent[i], rd);
    end
    wb_read(ADDR_STATUS, rd);
    check_eq("loop_dr_clear", 0, rd[LS_DR]);

    // overrun, one byte more than the rx fifo holds
    sent.delete();
    wb_write(ADDR_CTRL, DIV_CFG | IE_RLS);
    for (int i = 0; i < DEPTH + 1; i++)
    begin
      sent.push_back(8'($urandom()));
      wb_write(ADDR_DATA, {24'd0, sent[i]});
    end
    while (irq !== 1'b1)
      @(negedge clk);
    wb_read(ADDR_IIR, rd);
    check_eq("ovr_iir", {28'd0, II_RLS, 1'b0}, rd);
    wb_read(ADDR_STATUS, rd);
    check_eq("ovr_oe_set", 1, rd[LS_OE]);
    wb_read(ADDR_STATUS, rd);     // previous read cleared it
    check_eq("ovr_oe_clear", 0, rd[LS_OE]);
    for (int i = 0; i < DEPTH; i++)
    begin
      wb_read(ADDR_DATA, rd);
      check_eq("ovr_data", sent[i], rd);
    end
    wait_status(32'd1 << LS_TE);

    // interrupt enables and priority
    wb_write(ADDR_CTRL, DIV_CFG | IE_THRE);
    @(negedge clk);               // int lags its condition by one cycle
    check_eq("thre_int", 1, irq);
    wb_read(ADDR_IIR, rd);
    check_eq("thre_iir", {28'd0, II_THRE, 1'b0}, rd);
    wb_write(ADDR_CTRL, DIV_CFG | IE_THRE | IE_RDA);
    b = 8'($urandom());
    wb_write(ADDR_DATA, {24'd0, b});
    wait_status((32'd1 << LS_DR) | (32'd1 << LS_TE));  // both pending, rda must win
    wb_read(ADDR_IIR, rd);
    check_eq("rda_iir", {28'd0, II_RDA, 1'b0}, rd);
    check_eq("rda_int", 1, irq);
    wb_read(ADDR_DATA, rd);
    check_eq("rda_data", b, rd);
    wb_write(ADDR_CTRL, DIV_CFG);
    @(negedge clk);
    check_eq("int_off", 0, irq);
    wb_read(ADDR_IIR, rd);
    check_eq("none_iir", 32'h1, rd);

    $display("** PASS **");
    $finish;
  end

endmodule

// ==== sim.f ====
rtl/uart_pkg.sv
rtl/uart_fifo.sv
rtl/uart_baud_gen.sv
rtl/uart_tx.sv
rtl/uart_rx.sv
rtl/uart_regs.sv
rtl/uart_top.sv
bench/tb_clkgen.sv
bench/uart_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0 -Wno-fatal
TOP       ?= uart_tb
FILELIST  ?= sim.f

.PHONY: simulate clean

simulate:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir
